//--- verilog.f
logic/i2c_pkg.sv
logic/i2c_req_if.sv
logic/i2c_apb_port.sv
logic/i2c_arbiter.sv
logic/i2c_master.sv
logic/i2c_subsystem_top.sv
testbench/i2c_checker.sv
testbench/tb_top.sv

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top import i2c_pkg::*; ();

    localparam int FRAMES  = 28;
    localparam int TIMEOUT = FRAMES * 40 * CLKS_PER_QUARTER * 6 / 5;

    logic             clk;
    logic             reset;
    logic [1:0]       psel;
    logic [1:0]       penable;
    logic [1:0]       pwrite;
    logic [1:0][3:0]  paddr;
    logic [1:0][31:0] pwdata;
    logic [1:0][31:0] prdata;
    logic [1:0]       pslverr;
    logic             scl;
    logic             sda;
    logic             sda_oe;
    logic             tgt_drive;
    logic             t_scl_q;
    logic             t_sda_q;
    logic             t_byte;
    int               t_cnt;
    logic [7:0]       t_sh;
    logic [8*16-1:0]  test_name;
    int               cycles = 0;
    logic [1:0]       acc;

    assign sda = ~sda_oe & ~tgt_drive;     // Open drain bus
    assign acc = psel & penable & pwrite & ~pslverr &
                 {paddr[1] == REG_TX, paddr[0] == REG_TX};

    i2c_subsystem_top dut (
        .i_clk(clk), .i_reset(reset),
        .i_psel_0(psel[0]), .i_penable_0(penable[0]), .i_pwrite_0(pwrite[0]),
        .i_paddr_0(paddr[0]), .i_pwdata_0(pwdata[0]), .o_prdata_0(prdata[0]),
        .o_pslverr_0(pslverr[0]),
        .i_psel_1(psel[1]), .i_penable_1(penable[1]), .i_pwrite_1(pwrite[1]),
        .i_paddr_1(paddr[1]), .i_pwdata_1(pwdata[1]), .o_prdata_1(prdata[1]),
        .o_pslverr_1(pslverr[1]),
        .o_scl(scl), .i_sda(sda), .o_sda_oe(sda_oe)
    );

    i2c_checker chk (
        .i_clk(clk), .i_reset(reset),
        .i_acc_0(acc[0]), .i_wdata_0(pwdata[0]),
        .i_acc_1(acc[1]), .i_wdata_1(pwdata[1]),
        .i_scl(scl), .i_sda(sda), .i_test(test_name)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the DUT never finished its frames", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Target ACKs 7'h3c and 7'h51 plus every data byte
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            tgt_drive <= 1'b0;
            t_scl_q   <= 1'b1;
            t_sda_q   <= 1'b1;
            t_cnt     <= 0;
            t_byte    <= 1'b0;
        end else begin
            t_scl_q <= scl;
            t_sda_q <= sda;
            if (t_scl_q && scl && t_sda_q && !sda) begin
                t_cnt     <= 0;
                t_byte    <= 1'b0;
                tgt_drive <= 1'b0;
            end else if (!t_scl_q && scl) begin
                if (t_cnt < 8) begin
                    t_sh  <= {t_sh[6:0], sda};
                    t_cnt <= t_cnt + 1;
                end else begin
                    t_cnt  <= 0;
                    t_byte <= 1'b1;
                end
            end else if (t_scl_q && !scl) begin
                if (tgt_drive)
                    tgt_drive <= 1'b0;
                else if (t_cnt == 8)
                    tgt_drive <= t_byte | (t_sh[7:1] == 7'h3c) | (t_sh[7:1] == 7'h51);
            end
        end
    end

    task automatic apb_access(input int p, input logic wr, input logic [3:0] a,
                              input logic [31:0] d, output logic [31:0] rd,
                              output logic err);
        @(negedge clk);
        psel[p]    = 1'b1;
        pwrite[p]  = wr;
        paddr[p]   = a;
        pwdata[p]  = d;
        penable[p] = 1'b0;
        @(negedge clk);
        penable[p] = 1'b1;
        #1;
        rd  = prdata[p];
        err = pslverr[p];
        @(negedge clk);
        psel[p]    = 1'b0;
        penable[p] = 1'b0;
    endtask

    task automatic send(input int p, input logic [6:0] a, input logic [7:0] d,
                        output logic err);
        logic [31:0] rd;
        apb_access(p, 1'b1, REG_TX, {17'b0, a, d}, rd, err);
    endtask

    task automatic wait_done(input int p, output logic [31:0] st);
        logic err;
        do
            apb_access(p, 1'b0, REG_STATUS, 32'h0, st, err);
        while (!st[ST_DONE]);
    endtask

    task automatic random_stream(input int p, input int n);
        logic [6:0]  a;
        logic [31:0] st;
        logic        err;
        int          r;
        for (int k = 0; k < n; k++) begin
            r = $urandom % 3;
            a = (r == 0) ? 7'h3c : (r == 1) ? 7'h51 : 7'($urandom);
            if (r == 2 && (a == 7'h3c || a == 7'h51))
                a = a ^ 7'h01;
            send(p, a, 8'($urandom), err);
            chk.check_value("rand_pslverr", 0, err);
            wait_done(p, st);
            chk.check_value("rand_nack", (a != 7'h3c) && (a != 7'h51), st[ST_NACK]);
            repeat ($urandom % 4) @(negedge clk);
        end
    endtask

    initial begin
        logic [31:0] st0;
        logic [31:0] st1;
        logic        e0;
        logic        e1;
        int          base;
        int          n;
        void'($urandom(32'hf22b));
        clk = 0;
        reset = 1;
        psel = '0;
        penable = '0;
        pwrite = '0;
        paddr = '0;
        pwdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 0;

        test_name = "pair_reset";
        base = chk.nframes;
        fork
            send(0, 7'h3c, 8'h11, e0);
            send(1, 7'h51, 8'h22, e1);
        join
        fork
            wait_done(0, st0);
            wait_done(1, st1);
        join
        chk.check_value("first_addr", {7'h3c, 1'b0}, chk.addr_seen[base]);

        test_name = "single_ack";
        send(0, 7'h3c, 8'h96, e0);
        n = 0;
        while (dut.port0.busy) begin    // Busy already set by the access edge
            @(negedge clk);
            n++;
        end
        chk.check_value("busy_to_done", 200, n);
        wait_done(0, st0);
        chk.check_value("status", 32'h2, st0);

        test_name = "pair_second";
        base = chk.nframes;
        fork
            send(0, 7'h51, 8'h33, e0);
            send(1, 7'h3c, 8'h44, e1);
        join
        fork
            wait_done(0, st0);
            wait_done(1, st1);
        join
        chk.check_value("first_addr", {7'h3c, 1'b0}, chk.addr_seen[base]);

        test_name = "addr_nack";
        send(0, 7'h22, 8'hc3, e0);
        wait_done(0, st0);
        chk.check_value("status", 32'h6, st0);

        test_name = "busy_write";
        send(1, 7'h3c, 8'ha5, e1);
        chk.check_value("first_pslverr", 0, e1);
        send(1, 7'h51, 8'h5a, e1);
        chk.check_value("busy_pslverr", 1, e1);
        wait_done(1, st1);

        test_name = "random";
        fork
            random_stream(0, 10);
            random_stream(1, 10);
        join
        chk.check_value("pending", 0, chk.pend);

        $display("Run complete: %0d frames on the bus, %0d errors", chk.nframes, chk.errors);
        if (chk.errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- testbench/i2c_checker.sv
`timescale 1ns/1ps

module i2c_checker import i2c_pkg::*; (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_acc_0,      // Accepted REG_TX write
    input  logic [31:0]       i_wdata_0,
    input  logic              i_acc_1,
    input  logic [31:0]       i_wdata_1,
    input  logic              i_scl,
    input  logic              i_sda,
    input  logic [8*16-1:0]   i_test
);

    int         errors = 0;
    int         nframes = 0;
    logic [7:0] addr_seen [0:63];   // Address byte of each frame on the bus
    logic [1:0] pend;
    logic [1:0] pend_d;         // Pending set as seen by the engine at acceptance
    i2c_frame_t exp_fr [0:1];
    logic       last;
    logic       cur;
    logic       pk;
    logic       scl_q;
    logic       sda_q;
    logic [7:0] sh;
    int         cnt;
    int         nbytes;
    logic [7:0] bytes_rx [0:1];
    logic       ack_rx [0:1];

    // Ties go to the port not served last
    function automatic logic pick_port(input logic [1:0] p, input logic last_p);
        if (p == 2'b11)
            return ~last_p;
        return p[1];
    endfunction

    function automatic logic target_acks(input logic [6:0] a);
        return (a == 7'h3c) || (a == 7'h51);
    endfunction

    task automatic check_value(input logic [8*16-1:0] what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %0s %0s expected %0h actual %0h", i_test, what, exp, act);
        end
    endtask

    task automatic frame_done();
        i2c_frame_t e;
        logic       e_nack;
        e      = exp_fr[cur];
        e_nack = ~target_acks(e.addr);
        check_value("addr_byte", {e.addr, 1'b0}, bytes_rx[0]);
        check_value("addr_nack", e_nack, ack_rx[0]);
        check_value("byte_count", e_nack ? 1 : 2, nbytes);
        if (!e_nack) begin
            check_value("data_byte", e.data, bytes_rx[1]);
            check_value("data_ack", 0, ack_rx[1]);
        end
    endtask

    assign pk = pick_port(pend_d, last);

    always @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            pend   <= '0;
            pend_d <= '0;
            last   <= 1'b1;
            scl_q  <= 1'b1;
            sda_q  <= 1'b1;
            cnt    <= 0;
            nbytes <= 0;
        end else begin
            scl_q  <= i_scl;
            sda_q  <= i_sda;
            pend_d <= pend;
            if (scl_q && i_scl && sda_q && !i_sda) begin    // START
                cnt    <= 0;
                nbytes <= 0;
                if (pend_d == 2'b00) begin
                    errors++;
                    $display("START seen on the bus with no request pending (%0s)", i_test);
                end else begin
                    cur             <= pk;
                    last            <= pk;
                    pend[pk]        <= 1'b0;
                    pend_d[pk]      <= 1'b0;
                    nframes         <= nframes + 1;
                end
            end else if (scl_q && i_scl && !sda_q && i_sda) begin   // STOP
                frame_done();
                addr_seen[nframes - 1] <= bytes_rx[0];
            end else if (!scl_q && i_scl) begin
                if (cnt < 8) begin
                    sh  <= {sh[6:0], i_sda};
                    cnt <= cnt + 1;
                end else begin
                    cnt <= 0;
                    if (nbytes < 2) begin
                        bytes_rx[nbytes] <= sh;
                        ack_rx[nbytes]   <= i_sda;
                    end
                    nbytes <= nbytes + 1;
                end
            end
            if (i_acc_0) begin
                pend[0]   <= 1'b1;
                exp_fr[0] <= i2c_frame_t'(i_wdata_0[14:0]);
            end
            if (i_acc_1) begin
                pend[1]   <= 1'b1;
                exp_fr[1] <= i2c_frame_t'(i_wdata_1[14:0]);
            end
        end
    end

endmodule

//--- logic/i2c_subsystem_top.sv
`timescale 1ns/1ps

module i2c_subsystem_top import i2c_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_psel_0,
    input  logic                  i_penable_0,
    input  logic                  i_pwrite_0,
    input  logic [APB_ADDR_W-1:0] i_paddr_0,
    input  logic [APB_DATA_W-1:0] i_pwdata_0,
    output logic [APB_DATA_W-1:0] o_prdata_0,
    output logic                  o_pslverr_0,
    input  logic                  i_psel_1,
    input  logic                  i_penable_1,
    input  logic                  i_pwrite_1,
    input  logic [APB_ADDR_W-1:0] i_paddr_1,
    input  logic [APB_DATA_W-1:0] i_pwdata_1,
    output logic [APB_DATA_W-1:0] o_prdata_1,
    output logic                  o_pslverr_1,
    output logic                  o_scl,
    input  logic                  i_sda,
    output logic                  o_sda_oe
);

    i2c_req_if port0_req ();
    i2c_req_if port1_req ();
    i2c_req_if eng_req ();

    i2c_apb_port port0 (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_psel    (i_psel_0),
        .i_penable (i_penable_0),
        .i_pwrite  (i_pwrite_0),
        .i_paddr   (i_paddr_0),
        .i_pwdata  (i_pwdata_0),
        .o_prdata  (o_prdata_0),
        .o_pslverr (o_pslverr_0),
        .req       (port0_req.requester)
    );

    i2c_apb_port port1 (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_psel    (i_psel_1),
        .i_penable (i_penable_1),
        .i_pwrite  (i_pwrite_1),
        .i_paddr   (i_paddr_1),
        .i_pwdata  (i_pwdata_1),
        .o_prdata  (o_prdata_1),
        .o_pslverr (o_pslverr_1),
        .req       (port1_req.requester)
    );

    i2c_arbiter arbiter (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .req0    (port0_req.responder),
        .req1    (port1_req.responder),
        .eng     (eng_req.requester)
    );

    i2c_master engine (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .req      (eng_req.responder),
        .o_scl    (o_scl),
        .i_sda    (i_sda),
        .o_sda_oe (o_sda_oe)
    );

endmodule

//--- logic/i2c_master.sv
`timescale 1ns/1ps

module i2c_master import i2c_pkg::*; (
    input  logic         i_clk,
    input  logic         i_reset,
    i2c_req_if.responder req,
    output logic         o_scl,
    input  logic         i_sda,
    output logic         o_sda_oe      // Pull SDA low
);

    // Phase counts half clocks in steps of two, so a bit lasts 2 x CLKS_PER_QUARTER clocks
    localparam int PH_W = $clog2(QUARTERS_PER_BIT * CLKS_PER_QUARTER);
    localparam logic [PH_W-1:0] PH_STEP     = PH_W'(2);
    localparam logic [PH_W-1:0] PH_HALF_END = PH_W'(2 * CLKS_PER_QUARTER - 2);
    localparam logic [PH_W-1:0] PH_BIT_END  = PH_W'(QUARTERS_PER_BIT * CLKS_PER_QUARTER - 2);
    localparam logic [PH_W-1:0] PH_SAMPLE   = PH_W'(2 * CLKS_PER_QUARTER);

    typedef enum logic [3:0] {
        IDLE,
        START_A,
        START_B,
        ADDR,
        ADDR_ACK,
        DATA,
        DATA_ACK,
        STOP_A,
        STOP_B
    } state_e;

    state_e          state;
    state_e          state_next;
    logic [PH_W-1:0] ph;
    logic [PH_W-1:0] ph_next;
    logic [1:0]      quarter;
    logic            scl_high;
    logic [2:0]      bit_cnt;
    logic [2:0]      bit_cnt_next;
    logic [7:0]      shreg;
    logic [7:0]      data_byte;
    logic            nack_r;
    logic            nack_next;
    logic            scl_next;
    logic            oe_next;

    assign quarter  = 2'(ph / CLKS_PER_QUARTER);
    assign scl_high = (quarter == 2'd1) || (quarter == 2'd2);
    assign req.nack = nack_r;

    always_comb begin
        state_next    = state;
        ph_next       = ph + PH_STEP;
        bit_cnt_next  = bit_cnt;
        nack_next     = nack_r;
        scl_next      = 1'b1;
        oe_next       = 1'b0;
        req.req_ready = 1'b0;
        req.done      = 1'b0;

        case (state)
            IDLE: begin
                req.req_ready = 1'b1;
                ph_next       = '0;
                if (req.req_valid) begin
                    state_next   = START_A;
                    ph_next      = PH_STEP;     // Accept cycle is the first START clock
                    bit_cnt_next = '0;
                    nack_next    = 1'b0;
                end
            end
            START_A: begin
                oe_next = 1'b1;                 // SDA falls with SCL high
                if (ph == PH_HALF_END) begin
                    state_next = START_B;
                    ph_next    = '0;
                end
            end
            START_B: begin
                scl_next = 1'b0;
                oe_next  = 1'b1;
                if (ph == PH_HALF_END) begin
                    state_next = ADDR;
                    ph_next    = '0;
                end
            end
            ADDR, DATA: begin
                scl_next = scl_high;
                oe_next  = ~shreg[7];
                if (ph == PH_BIT_END) begin
                    ph_next      = '0;
                    bit_cnt_next = bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7)
                        state_next = (state == ADDR) ? ADDR_ACK : DATA_ACK;
                end
            end
            ADDR_ACK, DATA_ACK: begin
                scl_next = scl_high;
                if (ph == PH_SAMPLE)
                    nack_next = i_sda;          // Middle of SCL high
                if (ph == PH_BIT_END) begin
                    ph_next    = '0;
                    state_next = (state == ADDR_ACK && !nack_r) ? DATA : STOP_A;
                end
            end
            STOP_A: begin
                scl_next = (quarter != 2'd0);
                oe_next  = 1'b1;
                if (ph == PH_HALF_END) begin
                    state_next = STOP_B;
                    ph_next    = '0;
                end
            end
            STOP_B: begin
                if (ph == PH_HALF_END) begin
                    req.done   = 1'b1;
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= IDLE;
            ph       <= '0;
            bit_cnt  <= '0;
            nack_r   <= 1'b0;
            o_scl    <= 1'b1;
            o_sda_oe <= 1'b0;
        end else begin
            state    <= state_next;
            ph       <= ph_next;
            bit_cnt  <= bit_cnt_next;
            nack_r   <= nack_next;
            o_scl    <= scl_next;
            o_sda_oe <= oe_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == IDLE && req.req_valid) begin
            shreg     <= {req.frame.addr, 1'b0};    // W bit is 0
            data_byte <= req.frame.data;
        end else if ((state == ADDR || state == DATA) && ph == PH_BIT_END) begin
            shreg <= {shreg[6:0], 1'b0};
        end else if (state == ADDR_ACK && ph == PH_BIT_END) begin
            shreg <= data_byte;
        end
    end

endmodule

//--- logic/i2c_arbiter.sv
`timescale 1ns/1ps

module i2c_arbiter import i2c_pkg::*; (
    input  logic         i_clk,
    input  logic         i_reset,
    i2c_req_if.responder req0,
    i2c_req_if.responder req1,
    i2c_req_if.requester eng
);

    logic locked;       // Engine owned by gnt
    logic gnt;
    logic last_served;
    logic pick;
    logic sel;
    logic take;

    // Round robin only matters when both ports are waiting
    always_comb begin
        if (req0.req_valid && req1.req_valid)
            pick = ~last_served;
        else
            pick = req1.req_valid;
    end

    assign sel  = locked ? gnt : pick;
    assign take = eng.req_valid & eng.req_ready;

    assign eng.req_valid = ~locked & (sel ? req1.req_valid : req0.req_valid);
    assign eng.frame     = sel ? req1.frame : req0.frame;

    assign req0.req_ready = ~locked & eng.req_ready & ~sel;
    assign req1.req_ready = ~locked & eng.req_ready & sel;

    // Completion goes back to the owner only
    assign req0.done = locked & ~gnt & eng.done;
    assign req1.done = locked & gnt & eng.done;
    assign req0.nack = ~gnt & eng.nack;
    assign req1.nack = gnt & eng.nack;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            locked      <= 1'b0;
            gnt         <= 1'b0;
            last_served <= 1'b1;    // Port 0 wins the first tie
        end else if (take) begin
            locked      <= 1'b1;
            gnt         <= pick;
            last_served <= pick;
        end else if (locked && eng.done) begin
            locked <= 1'b0;
        end
    end

endmodule

//--- logic/i2c_apb_port.sv
`timescale 1ns/1ps

module i2c_apb_port import i2c_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [APB_ADDR_W-1:0] i_paddr,
    input  logic [APB_DATA_W-1:0] i_pwdata,
    output logic [APB_DATA_W-1:0] o_prdata,
    output logic                  o_pslverr,
    i2c_req_if.requester          req
);

    logic       access;
    logic       hit_tx;
    logic       hit_status;
    logic       tx_write;
    logic       busy;
    logic       done_st;
    logic       nack_st;
    logic       valid_r;
    i2c_frame_t frame_r;

    assign access     = i_psel & i_penable;
    assign hit_tx     = (i_paddr == REG_TX);
    assign hit_status = (i_paddr == REG_STATUS);
    assign tx_write   = access & i_pwrite & hit_tx & ~busy;

    // Unknown offset, or a launch while a frame is still pending
    assign o_pslverr = access & ((~hit_tx & ~hit_status) | (i_pwrite & hit_tx & busy));

    always_comb begin
        o_prdata = '0;
        if (access && !i_pwrite && hit_status) begin
            o_prdata[ST_BUSY] = busy;
            o_prdata[ST_DONE] = done_st;
            o_prdata[ST_NACK] = nack_st;
        end
    end

    always_ff @(posedge i_clk) begin
        if (tx_write) begin
            frame_r.addr <= i_pwdata[14:8];
            frame_r.data <= i_pwdata[7:0];
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            busy    <= 1'b0;
            done_st <= 1'b0;
            nack_st <= 1'b0;
            valid_r <= 1'b0;
        end else if (tx_write) begin
            busy    <= 1'b1;
            done_st <= 1'b0;
            nack_st <= 1'b0;
            valid_r <= 1'b1;
        end else begin
            if (valid_r && req.req_ready)
                valid_r <= 1'b0;    // Handshake taken
            if (req.done) begin
                busy    <= 1'b0;
                done_st <= 1'b1;
                nack_st <= req.nack;
            end
        end
    end

    assign req.req_valid = valid_r;
    assign req.frame     = frame_r;

endmodule

//--- logic/i2c_req_if.sv
`timescale 1ns/1ps

interface i2c_req_if import i2c_pkg::*; ();

    logic       req_valid;
    i2c_frame_t frame;
    logic       req_ready;
    logic       done;       // One-cycle pulse
    logic       nack;       // Valid with done

    modport requester (
        output req_valid,
        output frame,
        input  req_ready,
        input  done,
        input  nack
    );

    modport responder (
        input  req_valid,
        input  frame,
        output req_ready,
        output done,
        output nack
    );

endinterface

//--- logic/i2c_pkg.sv
package i2c_pkg;

    // SCL timing base
    localparam int CLKS_PER_QUARTER = 5;
    localparam int QUARTERS_PER_BIT = 4;

    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;

    // Register offsets
    localparam logic [APB_ADDR_W-1:0] REG_TX     = 4'h0;  // Data 7:0, target address 14:8
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'h4;

    // Status word bits
    localparam int ST_BUSY = 0;
    localparam int ST_DONE = 1;
    localparam int ST_NACK = 2;

    typedef struct packed {
        logic [6:0] addr;
        logic [7:0] data;
    } i2c_frame_t;

endpackage
